/* list.f */
+incdir+testbench
source/if_pkg.sv
source/prefetch_unit.sv
source/dummy_instr_gen.sv
source/compressed_decoder.sv
source/if_id_pipe.sv
source/if_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_instr_mem.sv
testbench/tb_if_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_if_stage \
  -o sim_if_stage > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_if_stage > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log || exit 1

/* testbench/tb_mem_content.svh */
// Program image for the memory model and the reference; even words hold one 32-bit instruction

// One compressed halfword picked from the supported set plus two unsupported codes
function automatic logic [15:0] c_half(input logic [29:0] w, input logic hi);
  logic [2:0] sel;
  logic [4:0] f;
  logic [4:0] r;
  sel = w[3:1] + {2'b00, hi};
  f   = w[8:4] ^ {sel, 2'b01};
  r   = w[14:10] | 5'd1;                 // Nonzero rs2
  case (sel)
    3'd0:    c_half = {3'b000, w[9], f, w[14:10], 2'b01};  // C.ADDI
    3'd1:    c_half = {3'b010, w[9], f, w[14:10], 2'b01};  // C.LI
    3'd2:    c_half = {4'b1000, f, r, 2'b10};              // C.MV
    3'd3:    c_half = {4'b1001, f, r, 2'b10};              // C.ADD
    3'd4:    c_half = {4'b1000, f | 5'd1, 5'd0, 2'b10};    // C.JR
    3'd5:    c_half = {w[15:2], 2'b00};                    // Quadrant 0
    3'd6:    c_half = {3'b111, w[9], f, r, 2'b01};         // C.BNEZ
    default: c_half = {3'b000, 1'b1, f, w[14:10], 2'b01};  // Negative C.ADDI
  endcase
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [29:0] w;
  w = addr[31:2];
  if (!w[0]) begin
    mem_word = {w[24:0] ^ 25'h013579b, 7'b0010011};
  end else begin
    mem_word = {c_half(w, 1'b1), c_half(w, 1'b0)};
  end
endfunction

/* testbench/tb_if_stage.sv */
// Expects pc_set_i together with kill_if_i; targets avoid 32-bit instructions across words
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  import if_pkg::*;

  `include "tb_mem_content.svh"

  localparam int WAIT_MAX      = 200;   // Cycles per wait for issues
  localparam int N_WAITS       = 9;
  // Every wait at its limit plus redirects, halt and reset
  localparam int BUDGET_CYCLES = N_WAITS * WAIT_MAX + 600;

  logic clk, rst_n;
  logic pc_set_i, kill_if_i, halt_if_i, id_ready_i, dummy_en_i;
  pc_mux_e pc_mux_i;
  logic [31:0] boot_addr_i, jump_target_i, mepc_i;
  logic [23:0] mtvec_addr_i;
  logic [4:0] irq_id_i;
  logic [DUMMY_CNT_W-1:0] dummy_freq_i;
  logic csr_mtvec_init_o, instr_req_o, instr_gnt_i, instr_rvalid_i, if_valid_o, if_busy_o;
  logic [31:0] instr_addr_o, instr_rdata_i, id_instr_o, id_pc_o;
  logic id_valid_o, id_compressed_o, id_illegal_c_o, id_dummy_o;

  int errors, checks, issue_cnt, n_comp, n_illegal, n_dummy;
  logic rand_ready;

  // Reference model state
  logic [31:0] model_pc;
  int dcnt;
  logic dpend, prev_issued, prev_ready, prev_req;
  logic [31:0] exp_instr, exp_pc, snap_instr, snap_pc;
  logic exp_dummy, exp_comp, exp_ill;
  logic [3:0] snap_flags;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  tb_instr_mem u_mem (
    .clk(clk), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_o(instr_gnt_i), .rvalid_o(instr_rvalid_i), .rdata_o(instr_rdata_i)
  );

  if_stage dut0 (.*);

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Returns {illegal, expanded instruction}
  function automatic logic [32:0] ref_expand(input logic [31:0] raw);
    c_instr_u c;
    logic [11:0] imm;
    c   = raw[15:0];
    imm = {{7{c.ci.imm5}}, c.ci.imm4_0};
    if (raw[1:0] == 2'b11) return {1'b0, raw};
    if (c.ci.op == 2'b01 && c.ci.funct3 == 3'b000)
      return {1'b0, imm, c.ci.rd_rs1, 3'b000, c.ci.rd_rs1, OPCODE_OPIMM};
    if (c.ci.op == 2'b01 && c.ci.funct3 == 3'b010)
      return {1'b0, imm, 5'd0, 3'b000, c.ci.rd_rs1, OPCODE_OPIMM};
    if (c.cr.op == 2'b10 && c.cr.funct4 == 4'b1000 && c.cr.rs2 != 0)
      return {1'b0, 7'd0, c.cr.rs2, 5'd0, 3'b000, c.cr.rd_rs1, OPCODE_OP};
    if (c.cr.op == 2'b10 && c.cr.funct4 == 4'b1000 && c.cr.rd_rs1 != 0)
      return {1'b0, 12'd0, c.cr.rd_rs1, 3'b000, 5'd0, OPCODE_JALR};
    if (c.cr.op == 2'b10 && c.cr.funct4 == 4'b1001 && c.cr.rs2 != 0)
      return {1'b0, 7'd0, c.cr.rs2, c.cr.rd_rs1, 3'b000, c.cr.rd_rs1, OPCODE_OP};
    return {1'b1, 16'h0000, raw[15:0]};
  endfunction

  function automatic logic [31:0] redirect_target(input pc_mux_e m);
    case (m)
      PC_BOOT:     return {boot_addr_i[31:2], 2'b00};
      PC_TRAP_EXC: return {mtvec_addr_i, 8'h00};
      PC_TRAP_IRQ: return {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};
      PC_MRET:     return {mepc_i[31:1], 1'b0};
      default:     return {jump_target_i[31:1], 1'b0};
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Comparing process, mid cycle when everything is settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    logic issued;
    logic [31:0] raw;
    logic [32:0] e;
    if (rst_n) begin
      checks++;
      if (prev_issued) begin
        if (!id_valid_o || id_pc_o !== exp_pc || id_dummy_o !== exp_dummy)
          report_mismatch($sformatf("pc %h dummy %b, expected pc %h dummy %b",
                                    id_pc_o, id_dummy_o, exp_pc, exp_dummy));
        else if (exp_dummy && (id_instr_o[6:0] != OPCODE_OP || id_instr_o[14:7] != 0 ||
                 id_instr_o[31:25] != 0 || id_compressed_o || id_illegal_c_o))
          report_mismatch($sformatf("bad dummy %h", id_instr_o));
        else if (!exp_dummy && (id_instr_o !== exp_instr || id_compressed_o !== exp_comp ||
                 id_illegal_c_o !== exp_ill))
          report_mismatch($sformatf("pc %h instr %h c%b i%b, expected %h c%b i%b", id_pc_o,
                          id_instr_o, id_compressed_o, id_illegal_c_o, exp_instr, exp_comp,
                          exp_ill));
        if (id_valid_o) begin               // What ID actually received
          if (id_compressed_o) n_comp++;
          if (id_illegal_c_o) n_illegal++;
          if (id_dummy_o) n_dummy++;
        end
      end else if (!prev_ready) begin
        if ({id_valid_o, id_compressed_o, id_illegal_c_o, id_dummy_o} !== snap_flags ||
            id_instr_o !== snap_instr || id_pc_o !== snap_pc)
          report_mismatch("id fields changed while id_ready_i low");
      end else if (id_valid_o) begin
        report_mismatch("id_valid_o high with nothing issued");
      end
      if (csr_mtvec_init_o !== (pc_set_i && pc_mux_i == PC_BOOT))
        report_mismatch("csr_mtvec_init_o wrong");
      if (halt_if_i && if_valid_o)
        report_mismatch("if_valid_o high during halt");
      if (kill_if_i && if_valid_o)
        report_mismatch("if_valid_o high during kill");
      // A new request fetches the word the model PC points at
      if (instr_req_o && !prev_req && instr_addr_o !== {model_pc[31:2], 2'b00})
        report_mismatch($sformatf("instr_addr_o %h, expected %h", instr_addr_o,
                                  {model_pc[31:2], 2'b00}));

      issued = if_valid_o && id_ready_i;
      if (issued) begin
        issue_cnt++;
        exp_pc = model_pc;
        if (dpend) begin
          exp_dummy = 1'b1;
          dpend     = 1'b0;
          dcnt      = 0;
        end else begin
          exp_dummy = 1'b0;
          raw = mem_word({model_pc[31:2], 2'b00});
          if (model_pc[1]) raw = {16'h0000, raw[31:16]};
          e         = ref_expand(raw);
          exp_instr = e[31:0];
          exp_ill   = e[32];
          exp_comp  = (raw[1:0] != 2'b11);
          model_pc  += exp_comp ? 32'd2 : 32'd4;
          if (dcnt == dummy_freq_i) begin   // n+1 real instructions seen
            dpend = 1'b1;
            dcnt  = 0;
          end else begin
            dcnt++;
          end
        end
      end
      if (pc_set_i || !dummy_en_i) begin
        dcnt  = 0;
        dpend = 1'b0;
      end
      if (pc_set_i) model_pc = redirect_target(pc_mux_i);
      snap_flags  = {id_valid_o, id_compressed_o, id_illegal_c_o, id_dummy_o};
      snap_instr  = id_instr_o;
      snap_pc     = id_pc_o;
      prev_issued = issued;
      prev_ready  = id_ready_i;
      prev_req    = instr_req_o;
    end
  end

  // Back pressure source
  always @(posedge clk) begin
    #2 id_ready_i = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic redirect(input pc_mux_e m);
    @(posedge clk);
    #2;
    pc_set_i  = 1'b1;
    kill_if_i = 1'b1;                    // Drop the instruction on the old path
    pc_mux_i  = m;
    @(posedge clk);
    #2;
    pc_set_i  = 1'b0;
    kill_if_i = 1'b0;
  endtask

  task automatic wait_issues(input int n);
    int target;
    int cyc;
    target = issue_cnt + n;
    cyc    = 0;
    while (issue_cnt < target && cyc < WAIT_MAX) begin
      @(posedge clk);
      cyc++;
    end
    if (issue_cnt < target) begin
      $display("Timeout: stage issued only %0d of %0d instructions", n - target + issue_cnt, n);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    $display("test %s: %0d errors", name, errors - err_before);
  endtask

  initial begin : watchdog
    #(BUDGET_CYCLES * 40 * 2);
    $display("Watchdog: run did not finish within its cycle budget");
    $display("sim failed");
    $finish;
  end

  initial begin
    int e0;
    int c0;
    int i0;
    void'($urandom(32'h3972_73b5));
    {pc_set_i, kill_if_i, halt_if_i, dummy_en_i, rand_ready} = '0;
    id_ready_i = 1'b1;
    pc_mux_i = PC_BOOT;
    boot_addr_i = 32'h0000_1003;
    jump_target_i = 32'h0000_2007;           // Upper half of a compressed word
    mepc_i = 32'h0000_300c;
    mtvec_addr_i = 24'h000040;
    irq_id_i = 5'd5;
    dummy_freq_i = '0;
    {errors, checks, issue_cnt, n_comp, n_illegal, n_dummy, dcnt} = '0;
    {dpend, prev_issued, prev_req} = '0;
    prev_ready = 1'b1;
    model_pc = 32'h0;
    @(posedge rst_n);
    @(posedge clk);
    #2;
    if (instr_req_o || if_valid_o || id_valid_o || csr_mtvec_init_o || if_busy_o)
      report_mismatch("outputs not idle after reset");
    repeat (3) @(posedge clk);
    if (instr_req_o) report_mismatch("fetch started before pc_set_i");

    e0 = errors;
    redirect(PC_BOOT);
    wait_issues(12);
    finish_test("boot", e0);

    e0 = errors;
    c0 = n_comp;
    i0 = n_illegal;
    redirect(PC_JUMP);
    wait_issues(24);
    if (n_comp == c0 || n_illegal == i0) begin
      $display("Compressed test issued no compressed or no illegal instruction");
      errors++;
    end
    finish_test("compressed", e0);

    e0 = errors;
    redirect(PC_MRET);
    wait_issues(6);
    redirect(PC_TRAP_EXC);
    wait_issues(6);
    redirect(PC_TRAP_IRQ);
    wait_issues(6);
    redirect(PC_JUMP);
    wait_issues(6);
    finish_test("redirects", e0);

    e0 = errors;
    rand_ready = 1'b1;
    wait_issues(30);
    rand_ready = 1'b0;
    finish_test("back pressure", e0);

    e0 = errors;
    #2;
    dummy_en_i   = 1'b1;
    dummy_freq_i = 4'd2;
    redirect(PC_BOOT);
    wait_issues(20);
    #2 dummy_en_i = 1'b0;
    if (n_dummy == 0) begin
      $display("No dummy instruction was issued with dummies enabled");
      errors++;
    end
    finish_test("dummy", e0);

    e0 = errors;
    @(posedge clk);
    #2 halt_if_i = 1'b1;
    repeat (8) @(posedge clk);
    #2 halt_if_i = 1'b0;
    redirect(PC_TRAP_IRQ);
    wait_issues(5);
    finish_test("halt and kill", e0);

    repeat (2) @(posedge clk);
    $display("checks %0d, issued %0d, errors %0d", checks, issue_cnt, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_instr_mem.sv */
// Instruction memory with one transfer in flight; grant in the request cycle, rvalid 1 to 3 later
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem (
  input  logic        clk,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  `include "tb_mem_content.svh"

  int unsigned lat;                      // Cycles left until rvalid
  logic [31:0] addr_q;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = 32'h0;
    lat      = 0;
  end

  always @(posedge clk) begin
    #2;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    if (lat != 0) begin
      lat = lat - 1;
      if (lat == 0) begin
        rvalid_o = 1'b1;
        rdata_o  = mem_word(addr_q);
      end
    end else if (req_i) begin
      gnt_o  = 1'b1;                     // Same cycle grant
      addr_q = addr_i;
      lat    = $urandom_range(3, 1);
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Free running 40 ns clock; reset held low for the first 4 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_n_o = 1'b1;                   // Released off the edge like other inputs
  end

  always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* source/if_stage.sv */
// Fetch stage top with no PMP or debug targets; nothing is fetched before the first pc_set_i
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic                           clk,
  input  logic                           rst_n,

  // Redirect
  input  logic                           pc_set_i,
  input  if_pkg::pc_mux_e                pc_mux_i,
  input  logic [31:0]                    boot_addr_i,
  input  logic [31:0]                    jump_target_i,
  input  logic [31:0]                    mepc_i,
  input  logic [23:0]                    mtvec_addr_i,
  input  logic [4:0]                     irq_id_i,
  output logic                           csr_mtvec_init_o,

  // Stage and dummy control
  input  logic                           kill_if_i,
  input  logic                           halt_if_i,
  input  logic                           id_ready_i,
  input  logic                           dummy_en_i,
  input  logic [if_pkg::DUMMY_CNT_W-1:0] dummy_freq_i,

  // Instruction bus
  output logic                           instr_req_o,
  output logic [31:0]                    instr_addr_o,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [31:0]                    instr_rdata_i,

  output logic                           if_valid_o,
  output logic                           if_busy_o,

  // IF/ID register
  output logic                           id_valid_o,
  output logic [31:0]                    id_instr_o,
  output logic [31:0]                    id_pc_o,
  output logic                           id_compressed_o,
  output logic                           id_illegal_c_o,
  output logic                           id_dummy_o
);

  logic        fetch_valid;
  logic [31:0] fetch_instr;
  logic [31:0] fetch_pc;
  logic        fetch_ready;
  logic        dummy_insert;
  logic [31:0] dummy_instr;
  logic        instr_issued;

  prefetch_unit u_prefetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .fetch_ready_i    (fetch_ready),
    .fetch_valid_o    (fetch_valid),
    .fetch_instr_o    (fetch_instr),
    .fetch_pc_o       (fetch_pc),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .busy_o           (if_busy_o)
  );

  dummy_instr_gen u_dummy (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .dummy_en_i     (dummy_en_i),
    .dummy_freq_i   (dummy_freq_i),
    .instr_issued_i (instr_issued),
    .dummy_insert_o (dummy_insert),
    .dummy_instr_o  (dummy_instr)
  );

  if_id_pipe u_if_id (
    .clk             (clk),
    .rst_n           (rst_n),
    .kill_if_i       (kill_if_i),
    .halt_if_i       (halt_if_i),
    .id_ready_i      (id_ready_i),
    .fetch_valid_i   (fetch_valid),
    .fetch_instr_i   (fetch_instr),
    .fetch_pc_i      (fetch_pc),
    .fetch_ready_o   (fetch_ready),
    .dummy_insert_i  (dummy_insert),
    .dummy_instr_i   (dummy_instr),
    .instr_issued_o  (instr_issued),
    .if_valid_o      (if_valid_o),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_illegal_c_o  (id_illegal_c_o),
    .id_dummy_o      (id_dummy_o)
  );

endmodule

`default_nettype wire

/* source/if_id_pipe.sv */
// IF/ID register that freezes while ID stalls; payload fields are undefined until the first issue
`timescale 1ns/1ps
`default_nettype none

module if_id_pipe (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        kill_if_i,
  input  logic        halt_if_i,
  input  logic        id_ready_i,

  // Fetched stream
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_instr_i,
  input  logic [31:0] fetch_pc_i,
  output logic        fetch_ready_o,

  // Dummy stream
  input  logic        dummy_insert_i,
  input  logic [31:0] dummy_instr_i,
  output logic        instr_issued_o,
  output logic        if_valid_o,

  // IF/ID register
  output logic        id_valid_o,
  output logic [31:0] id_instr_o,
  output logic [31:0] id_pc_o,
  output logic        id_compressed_o,
  output logic        id_illegal_c_o,
  output logic        id_dummy_o
);

  logic [31:0] dec_instr;
  logic        dec_compressed;
  logic        dec_illegal;

  compressed_decoder u_decoder (
    .instr_i         (fetch_instr_i),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_o       (dec_illegal)
  );

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  // Kill drains the fetched instruction; a pending dummy holds it back
  assign fetch_ready_o  = kill_if_i || (id_ready_i && !dummy_insert_i && !halt_if_i);
  assign if_valid_o     = (fetch_valid_i || dummy_insert_i) && !kill_if_i && !halt_if_i;
  assign instr_issued_o = if_valid_o && id_ready_i;

  ////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (id_ready_i) begin
      id_valid_o <= if_valid_o;            // Clears when ID takes nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (instr_issued_o) begin
      id_instr_o      <= dummy_insert_i ? dummy_instr_i : dec_instr;
      id_pc_o         <= fetch_pc_i;       // Dummy borrows the PC of the waiting instruction
      id_compressed_o <= dec_compressed && !dummy_insert_i;
      id_illegal_c_o  <= dec_illegal && !dummy_insert_i;
      id_dummy_o      <= dummy_insert_i;
    end
  end

endmodule

`default_nettype wire

/* source/compressed_decoder.sv */
// Expands only C.ADDI C.LI C.MV C.ADD and C.JR; any other compressed code is flagged illegal
`timescale 1ns/1ps
`default_nettype none

module compressed_decoder (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  import if_pkg::*;

  c_instr_u   c_instr;
  logic [11:0] ci_imm;     // Sign extended CI immediate

  assign c_instr         = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);
  assign ci_imm          = {{6{c_instr.ci.imm5}}, c_instr.ci.imm5, c_instr.ci.imm4_0};

  ////////////////////////////////////////////////////////////
  // Expansion
  ////////////////////////////////////////////////////////////

  always_comb begin
    instr_o   = instr_i;                   // 32-bit words pass unchanged
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Unsupported halfword goes on zero extended
      instr_o   = {16'h0000, instr_i[15:0]};
      illegal_o = 1'b1;
      case (c_instr.ci.op)
        2'b01: begin
          case (c_instr.ci.funct3)
            3'b000: begin                  // C.ADDI
              instr_o   = {ci_imm, c_instr.ci.rd_rs1, 3'b000, c_instr.ci.rd_rs1, OPCODE_OPIMM};
              illegal_o = 1'b0;
            end
            3'b010: begin                  // C.LI
              instr_o   = {ci_imm, 5'd0, 3'b000, c_instr.ci.rd_rs1, OPCODE_OPIMM};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end
        2'b10: begin
          case (c_instr.cr.funct4)
            4'b1000: begin
              if (c_instr.cr.rs2 != 5'd0) begin
                // C.MV
                instr_o   = {7'b0000000, c_instr.cr.rs2, 5'd0, 3'b000,
                             c_instr.cr.rd_rs1, OPCODE_OP};
                illegal_o = 1'b0;
              end else if (c_instr.cr.rd_rs1 != 5'd0) begin
                // C.JR with rs1 zero is reserved
                instr_o   = {12'h000, c_instr.cr.rd_rs1, 3'b000, 5'd0, OPCODE_JALR};
                illegal_o = 1'b0;
              end
            end
            4'b1001: begin
              if (c_instr.cr.rs2 != 5'd0) begin
                // C.ADD
                instr_o   = {7'b0000000, c_instr.cr.rs2, c_instr.cr.rd_rs1, 3'b000,
                             c_instr.cr.rd_rs1, OPCODE_OP};
                illegal_o = 1'b0;
              end
            end
            default: ;
          endcase
        end
        default: ;                         // Quadrant 0 not in the subset
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/dummy_instr_gen.sv */
// Dummy interval counts issued real instructions up to dummy_freq_i plus one and resets on redirect
`timescale 1ns/1ps
`default_nettype none

module dummy_instr_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           pc_set_i,
  input  logic                           dummy_en_i,
  input  logic [if_pkg::DUMMY_CNT_W-1:0] dummy_freq_i,    // Real instructions between dummies minus one
  input  logic                           instr_issued_i,
  output logic                           dummy_insert_o,
  output logic [31:0]                    dummy_instr_o
);

  import if_pkg::*;

  logic [DUMMY_CNT_W-1:0] cnt_q;     // Real instructions since the last dummy
  logic                   insert_q;
  logic [15:0]            lfsr_q;
  logic                   lfsr_fb;

  ////////////////////////////////////////////////////////////
  // Operand LFSR
  ////////////////////////////////////////////////////////////

  // Taps 16 14 13 11 give a maximal length sequence
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};   // Steps every cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // Interval counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      insert_q <= 1'b0;
    end else if (pc_set_i || !dummy_en_i) begin
      cnt_q    <= '0;
      insert_q <= 1'b0;
    end else if (instr_issued_i) begin
      if (insert_q) begin                  // Dummy has priority so this issue was the dummy
        insert_q <= 1'b0;
        cnt_q    <= '0;
      end else if (cnt_q == dummy_freq_i) begin
        insert_q <= 1'b1;
        cnt_q    <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign dummy_insert_o = insert_q;

  // ADD x0 with random sources so it has no architectural effect
  assign dummy_instr_o = {7'b0000000, lfsr_q[9:5], lfsr_q[4:0], 3'b000, 5'd0, OPCODE_OP};

endmodule

`default_nettype wire

/* source/prefetch_unit.sv */
// One bus transfer in flight and a single word buffer; 32-bit instructions crossing a word are not handled
`timescale 1ns/1ps
`default_nettype none

module prefetch_unit (
  input  logic            clk,
  input  logic            rst_n,

  // Redirect
  input  logic            pc_set_i,
  input  if_pkg::pc_mux_e pc_mux_i,
  input  logic [31:0]     boot_addr_i,
  input  logic [31:0]     jump_target_i,
  input  logic [31:0]     mepc_i,
  input  logic [23:0]     mtvec_addr_i,     // mtvec base bits
  input  logic [4:0]      irq_id_i,

  // Toward the IF/ID stage
  input  logic            fetch_ready_i,
  output logic            fetch_valid_o,
  output logic [31:0]     fetch_instr_o,
  output logic [31:0]     fetch_pc_o,

  // Instruction bus
  output logic            instr_req_o,
  output logic [31:0]     instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [31:0]     instr_rdata_i,

  output logic            csr_mtvec_init_o,
  output logic            busy_o
);

  import if_pkg::*;

  logic [31:0] branch_addr;
  logic [31:0] pc_q;
  logic [31:0] pc_d;
  logic        fetch_en_q;   // Set by the first redirect
  logic        fetch_en_d;
  logic        buf_valid_q;
  logic        buf_valid_d;
  logic [29:0] buf_addr_q;   // Word address of buf_word_q
  logic [29:0] buf_addr_d;
  logic [31:0] buf_word_q;
  logic [29:0] req_addr_q;
  logic [1:0]  state_q;
  logic [1:0]  state_d;
  logic        discard_q;    // At most one stale response with a single transfer
  logic        discard_d;
  logic        load_buf;
  logic        consume;
  logic        need_fetch;

  ////////////////////////////////////////////////////////////
  // Redirect target
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     branch_addr = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     branch_addr = jump_target_i;
      PC_MRET:     branch_addr = mepc_i;
      PC_TRAP_EXC: branch_addr = {mtvec_addr_i, 8'h00};
      PC_TRAP_IRQ: branch_addr = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};  // Vectored
      default:     branch_addr = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////
  // Buffer output and PC
  ////////////////////////////////////////////////////////////

  assign fetch_valid_o = buf_valid_q && (buf_addr_q == pc_q[31:2]);
  // Upper halfword serves a compressed instruction on its own
  assign fetch_instr_o = pc_q[1] ? {16'h0000, buf_word_q[31:16]} : buf_word_q;
  assign fetch_pc_o    = pc_q;
  assign consume       = fetch_valid_o && fetch_ready_i;

  assign pc_d = pc_set_i ? {branch_addr[31:1], 1'b0} :
                consume  ? pc_q + ((fetch_instr_o[1:0] == 2'b11) ? 32'd4 : 32'd2) :
                           pc_q;

  // Responses after a redirect never reach the buffer
  assign load_buf    = (state_q == FETCH_WAIT) && instr_rvalid_i && !discard_q && !pc_set_i;
  assign buf_valid_d = !pc_set_i && (buf_valid_q || load_buf);
  assign buf_addr_d  = load_buf ? req_addr_q : buf_addr_q;
  assign fetch_en_d  = fetch_en_q || pc_set_i;
  assign need_fetch  = fetch_en_d && !(buf_valid_d && (buf_addr_d == pc_d[31:2]));

  ////////////////////////////////////////////////////////////
  // Bus FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    discard_d = discard_q;
    case (state_q)
      FETCH_IDLE: begin
        if (need_fetch) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (pc_set_i) begin
          discard_d = 1'b1;                  // Address stays put until granted
        end
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          discard_d = 1'b0;
          state_d   = need_fetch ? FETCH_REQ : FETCH_IDLE;
        end else if (pc_set_i) begin
          discard_d = 1'b1;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  assign instr_req_o  = (state_q == FETCH_REQ);
  assign instr_addr_o = {req_addr_q, 2'b00};
  assign busy_o       = (state_q != FETCH_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FETCH_IDLE;
      discard_q   <= 1'b0;
      fetch_en_q  <= 1'b0;
      buf_valid_q <= 1'b0;
      pc_q        <= 32'h0;
    end else begin
      state_q     <= state_d;
      discard_q   <= discard_d;
      fetch_en_q  <= fetch_en_d;
      buf_valid_q <= buf_valid_d;
      pc_q        <= pc_d;
    end
  end

  always_ff @(posedge clk) begin
    if (load_buf) begin
      buf_word_q <= instr_rdata_i;
    end
    buf_addr_q <= buf_addr_d;
    if ((state_d == FETCH_REQ) && (state_q != FETCH_REQ)) begin
      req_addr_q <= pc_d[31:2];            // Word the PC points at after this cycle
    end
  end

endmodule

`default_nettype wire

/* source/if_pkg.sv */
// Shared fetch stage definitions for RV32 only with fixed widths and no module parameters
`default_nettype none

package if_pkg;

  ////////////////////////////////////////////////////////////
  // Redirect sources
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,  // Boot address from the system
    PC_JUMP     = 3'd1,  // Jump target from ID
    PC_MRET     = 3'd2,  // Return to mepc
    PC_TRAP_EXC = 3'd3,  // Exceptions share the mtvec base
    PC_TRAP_IRQ = 3'd4   // Vectored interrupt entry
  } pc_mux_e;

  ////////////////////////////////////////////////////////////
  // Compressed instruction word
  ////////////////////////////////////////////////////////////

  // Same halfword seen as CI or CR format
  typedef union packed {
    struct packed {
      logic [2:0] funct3;
      logic       imm5;    // Immediate sign bit
      logic [4:0] rd_rs1;
      logic [4:0] imm4_0;
      logic [1:0] op;      // Quadrant
    } ci;
    struct packed {
      logic [3:0] funct4;
      logic [4:0] rd_rs1;
      logic [4:0] rs2;
      logic [1:0] op;
    } cr;
  } c_instr_u;

  // Major opcodes of the expanded forms
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR  = 7'h67;

  ////////////////////////////////////////////////////////////
  // Fetch FSM and dummy insertion
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] FETCH_IDLE = 2'd0;  // Buffer covers the PC or fetch not started
  localparam logic [1:0] FETCH_REQ  = 2'd1;  // Request held until granted
  localparam logic [1:0] FETCH_WAIT = 2'd2;  // Granted and waiting for rvalid

  localparam int unsigned DUMMY_CNT_W = 4;  // Interval field and counter width

  localparam logic [15:0] LFSR_SEED = 16'hACE1;  // Nonzero so the LFSR never locks up

endpackage

`default_nettype wire
